// File: verilog/fe_pkg.sv
package fe_pkg;

    typedef logic [63:0] pc_t;   // rv64 program counter
    typedef logic [31:0] inst_t; // one 32-bit instruction word

    // next-pc source, driven by decode
    typedef enum logic [1:0] {
        pc_seq = 2'd0,  // fetch pc plus 4
        pc_alu = 2'd1,  // jalr target
        pc_bru = 2'd2   // branch or jal target, falls back to seq when not taken
    } pc_sel_e;

    // decode to fetch, 131 bits
    typedef struct packed {
        pc_t     alu_target;
        pc_sel_e pc_sel;
        logic    taken;      // also squashes the IF content
        pc_t     bru_target;
    } redirect_t;

    // fetch to decode, 96 bits
    typedef struct packed {
        inst_t inst;
        pc_t   pc;
    } fs_to_ds_t;

    typedef fs_to_ds_t issue_t; // same layout on the issue port

    localparam inst_t NOP_INST = 32'h0000_0013; // addi x0, x0, 0
    localparam pc_t   PC_STEP  = 64'd4;

    // IF pc during reset sits one word before the start address
    // so the sequential pc of the reset cycle is the start address itself
    function automatic pc_t reset_pc_of(input pc_t start_pc);
        return start_pc - PC_STEP;
    endfunction

endpackage

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter fe_pkg::pc_t START_PC = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              hold,
    input  logic              ds_allowin,
    input  fe_pkg::redirect_t redirect,
    output logic              rom_en,
    output fe_pkg::pc_t       rom_addr,
    input  fe_pkg::inst_t     rom_data,
    output logic              fs_valid,
    output fe_pkg::fs_to_ds_t fs_bus
);
    import fe_pkg::*;

    localparam pc_t RESET_PC = reset_pc_of(START_PC);

    logic if_valid;     // IF stage holds an instruction
    logic to_fs_valid;
    logic fs_ready_go;
    logic fs_allowin;
    logic fs_flush;     // redirect from decode this cycle
    logic fs_load;      // new pc enters IF
    pc_t  fs_pc;
    pc_t  seq_pc;
    pc_t  wait_jump_pc;
    pc_t  nextpc;

    // pre-IF
    assign to_fs_valid  = !rst;
    assign seq_pc       = fs_pc + PC_STEP;
    assign wait_jump_pc = redirect.taken ? redirect.bru_target : seq_pc;

    always_comb begin
        case (redirect.pc_sel)
            pc_alu:  nextpc = redirect.alu_target;
            pc_bru:  nextpc = wait_jump_pc;
            default: nextpc = seq_pc;
        endcase
    end

    // IF handshake, hold freezes the stage
    assign fs_ready_go = !hold;
    assign fs_allowin  = (!if_valid || fs_ready_go && ds_allowin) && !hold;
    assign fs_valid    = if_valid && fs_ready_go;

    // a redirect reloads IF even under hold, its content is wrong-path anyway
    assign fs_flush = redirect.taken;
    assign fs_load  = to_fs_valid && (fs_allowin || fs_flush);

    always_ff @(posedge clk) begin
        if (rst) begin
            if_valid <= 1'b0;
        end else if (fs_allowin || fs_flush) begin
            if_valid <= to_fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fs_pc <= RESET_PC; // first nextpc is START_PC
        end else if (fs_load) begin
            fs_pc <= nextpc;
        end
    end

    // rom read issued together with the pc update
    assign rom_en   = fs_load;
    assign rom_addr = nextpc;

    // wrong-path instruction goes out as a nop with pc zero
    assign fs_bus.inst = fs_flush ? NOP_INST : rom_data;
    assign fs_bus.pc   = fs_flush ? pc_t'(0) : fs_pc;

endmodule

// File: verilog/inst_rom.sv
`timescale 1ns/1ps

module inst_rom #(
    parameter int ROM_DEPTH_LOG2 = 8
) (
    input  logic          clk,
    input  logic          en,
    input  fe_pkg::pc_t   addr,
    output fe_pkg::inst_t data
);

    localparam int DEPTH = 1 << ROM_DEPTH_LOG2;

    fe_pkg::inst_t mem [DEPTH];
    logic [ROM_DEPTH_LOG2-1:0] word_addr;

    initial begin
        $readmemh("program.hex", mem);
    end

    // byte address in, word index out
    assign word_addr = addr[ROM_DEPTH_LOG2+1:2];

    always_ff @(posedge clk) begin
        if (en) begin
            data <= mem[word_addr]; // holds while en is low
        end
    end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              fs_valid,
    input  fe_pkg::fs_to_ds_t fs_bus,
    output logic              ds_allowin,
    output fe_pkg::redirect_t redirect,
    input  logic              es_allowin,
    output logic              issue_valid,
    output fe_pkg::issue_t    issue
);
    import fe_pkg::*;

    localparam logic [6:0] OP_BRANCH = 7'b110_0011;
    localparam logic [6:0] OP_JALR   = 7'b110_0111;
    localparam logic [6:0] OP_JAL    = 7'b110_1111;

    logic       ds_valid;
    logic       ds_fire;     // item leaves ID this cycle
    logic       in_bubble;   // squashed nop from fetch
    fs_to_ds_t  ds_bus;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_jal;
    logic       is_jalr;
    logic       is_branch;
    logic       br_cond;
    pc_t        imm_b;
    pc_t        imm_j;
    pc_t        imm_i;
    pc_t        bru_target;
    pc_t        alu_target;

    assign in_bubble = (fs_bus.pc == pc_t'(0)) && (fs_bus.inst == NOP_INST);

    // ID handshake
    assign ds_allowin  = !ds_valid || es_allowin;
    assign ds_fire     = ds_valid && es_allowin;

    // a bubble leaves the stage empty
    always_ff @(posedge clk) begin
        if (rst) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid && !in_bubble;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_bus <= fs_bus;
        end
    end

    assign issue_valid = ds_valid;
    assign issue       = ds_bus;

    // classification
    assign opcode    = ds_bus.inst[6:0];
    assign funct3    = ds_bus.inst[14:12];
    assign is_jal    = opcode == OP_JAL;
    assign is_jalr   = (opcode == OP_JALR) && (funct3 == 3'b000);
    assign is_branch = opcode == OP_BRANCH;

    // sources read as zero, so only the equal and greater-or-equal forms are taken
    always_comb begin
        case (funct3)
            3'b000:  br_cond = 1'b1; // beq
            3'b101:  br_cond = 1'b1; // bge
            3'b111:  br_cond = 1'b1; // bgeu
            default: br_cond = 1'b0; // bne, blt, bltu
        endcase
    end

    // immediates
    assign imm_b = {{51{ds_bus.inst[31]}}, ds_bus.inst[31], ds_bus.inst[7],
                    ds_bus.inst[30:25], ds_bus.inst[11:8], 1'b0};
    assign imm_j = {{43{ds_bus.inst[31]}}, ds_bus.inst[31], ds_bus.inst[19:12],
                    ds_bus.inst[20], ds_bus.inst[30:21], 1'b0};
    assign imm_i = {{52{ds_bus.inst[31]}}, ds_bus.inst[31:20]};

    assign bru_target = ds_bus.pc + (is_jal ? imm_j : imm_b);
    assign alu_target = imm_i & ~pc_t'(1); // rs1 reads zero

    always_comb begin
        redirect            = '0;
        redirect.pc_sel     = pc_seq;
        redirect.alu_target = alu_target;
        redirect.bru_target = bru_target;
        if (ds_fire) begin
            if (is_jalr) begin
                redirect.pc_sel = pc_alu;
                redirect.taken  = 1'b1;
            end else if (is_jal) begin
                redirect.pc_sel = pc_bru;
                redirect.taken  = 1'b1;
            end else if (is_branch) begin
                redirect.pc_sel = pc_bru;  // not taken falls back to seq in fetch
                redirect.taken  = br_cond;
            end
        end
    end

endmodule

// File: verilog/frontend_top.sv
`timescale 1ns/1ps

module frontend_top #(
    parameter fe_pkg::pc_t START_PC       = '0,
    parameter int          ROM_DEPTH_LOG2 = 8
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           hold,        // hazard stall into fetch
    input  logic           es_allowin,
    output logic           issue_valid,
    output fe_pkg::issue_t issue
);
    import fe_pkg::*;

    logic      rom_en;
    pc_t       rom_addr;
    inst_t     rom_data;
    logic      fs_valid;
    fs_to_ds_t fs_bus;
    logic      ds_allowin;
    redirect_t redirect;

    fetch_stage #(
        .START_PC   (START_PC)
    ) fetch0 (
        .clk        (clk),
        .rst        (rst),
        .hold       (hold),
        .ds_allowin (ds_allowin),
        .redirect   (redirect),
        .rom_en     (rom_en),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .fs_valid   (fs_valid),
        .fs_bus     (fs_bus)
    );

    inst_rom #(
        .ROM_DEPTH_LOG2 (ROM_DEPTH_LOG2)
    ) rom0 (
        .clk            (clk),
        .en             (rom_en),
        .addr           (rom_addr),
        .data           (rom_data)
    );

    decode_stage decode0 (
        .clk         (clk),
        .rst         (rst),
        .fs_valid    (fs_valid),
        .fs_bus      (fs_bus),
        .ds_allowin  (ds_allowin),
        .redirect    (redirect),
        .es_allowin  (es_allowin),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

endmodule

// File: testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int HALF_PERIOD  = 10,  // 20 ns clock
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0; // released on a falling edge like every other input
    end

endmodule

// File: testbench/frontend_chk.sv
`timescale 1ns/1ps

module frontend_chk (
    input logic              clk,
    input logic              rst,
    input logic              es_allowin,
    input logic              ds_valid,
    input logic              issue_valid,
    input fe_pkg::issue_t    issue,
    input fe_pkg::redirect_t redirect
);

    int stable_fails   = 0;
    int reset_fails    = 0;
    int redirect_fails = 0;
    int fail_count;          // summed up for the closing report

    assign fail_count = stable_fails + reset_fails + redirect_fails;

    // a stalled issue keeps its item
    issue_stable_a: assert property (
        @(posedge clk) disable iff (rst)
        issue_valid && !es_allowin |=> issue_valid && $stable(issue)
    ) else begin
        stable_fails++;
        $error("issue changed or dropped while es_allowin was low");
    end

    issue_reset_a: assert property (
        @(posedge clk) rst |=> !issue_valid
    ) else begin
        reset_fails++;
        $error("issue_valid high in the cycle after reset");
    end

    // redirect only from a valid ID item
    redirect_valid_a: assert property (
        @(posedge clk) disable iff (rst)
        redirect.taken |-> ds_valid
    ) else begin
        redirect_fails++;
        $error("redirect taken while the ID stage is empty");
    end

endmodule

// File: testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter fe_pkg::pc_t START_PC       = '0,
    parameter int          ROM_DEPTH_LOG2 = 8
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           hold,
    input  logic           es_allowin,
    input  logic           issue_valid,
    input  fe_pkg::issue_t issue,
    output int             issue_count,
    output int             error_count
);
    import fe_pkg::*;

    localparam int DEPTH = 1 << ROM_DEPTH_LOG2;

    inst_t ref_mem [DEPTH];  // own copy of the program
    pc_t   exp_pc;           // pc the stream should show next
    int    quiet_run;        // stall-free cycles in a row
    logic  after_redirect;   // previous issue left the sequential path

    initial begin
        $readmemh("program.hex", ref_mem);
    end

    // successor of one instruction, every source register reads zero
    function automatic pc_t expected_next_pc(input pc_t pc, input inst_t inst);
        pc_t b_off;
        pc_t j_off;
        pc_t i_off;
        pc_t next;
        b_off = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        j_off = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        i_off = {{52{inst[31]}}, inst[31:20]};
        next  = pc + 64'd4;
        case (inst[6:0])
            7'b110_1111: next = pc + j_off;      // jal
            7'b110_0111: next = i_off & ~64'd1;  // jalr off x0
            7'b110_0011: begin
                // x0 == x0 and x0 >= x0 hold, the other three compares never do
                if (inst[14:12] == 3'd0 || inst[14:12] == 3'd5 || inst[14:12] == 3'd7) begin
                    next = pc + b_off;
                end
            end
            default: next = pc + 64'd4;
        endcase
        return next;
    endfunction

    always @(posedge clk) begin : compare
        int    found;
        logic  stalled;
        inst_t want_inst;
        pc_t   want_next;
        found     = 0;
        stalled   = hold || !es_allowin;
        want_inst = ref_mem[exp_pc[ROM_DEPTH_LOG2+1:2]];
        want_next = expected_next_pc(exp_pc, want_inst);
        if (rst) begin
            exp_pc         <= START_PC;
            issue_count    <= 0;
            error_count    <= 0;
            quiet_run      <= 0;
            after_redirect <= 1'b0;
        end else begin
            if (issue_valid && es_allowin) begin
                if (issue.pc !== exp_pc) begin
                    $display("CHECK FAILED at %0t: issue %0d pc %h, expected %h",
                             $time, issue_count, issue.pc, exp_pc);
                    found++;
                end
                if (issue.inst !== want_inst) begin
                    $display("CHECK FAILED at %0t: issue %0d inst %h, expected %h",
                             $time, issue_count, issue.inst, want_inst);
                    found++;
                end
                exp_pc         <= want_next;
                after_redirect <= want_next != exp_pc + 64'd4;
                issue_count    <= issue_count + 1;
            end else begin
                after_redirect <= 1'b0;
            end
            // steady flow loses one cycle per redirect and nothing else
            if (!issue_valid && !stalled && quiet_run >= 3 && issue_count > 0
                && !after_redirect) begin
                $display("CHECK FAILED at %0t: issue_valid low in a stall-free cycle",
                         $time);
                found++;
            end
            if (stalled) begin
                quiet_run <= 0;
            end else if (quiet_run < 8) begin
                quiet_run <= quiet_run + 1;
            end
            error_count <= error_count + found;
        end
    end

endmodule

// File: testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import fe_pkg::*;

    localparam pc_t START_PC       = 64'd0;
    localparam int  ROM_DEPTH_LOG2 = 8;
    localparam int  NUM_ISSUES     = 400;
    localparam int  MAX_CYCLES     = NUM_ISSUES * 4 + 50;
    localparam int  PHASE_LEN      = 32;   // cycles per stimulus phase
    localparam int  SEED           = 95;

    logic   clk;
    logic   rst;
    logic   hold;
    logic   es_allowin;
    logic   issue_valid;
    issue_t issue;
    int     issue_count;
    int     error_count;
    int     cycle_count;

    tb_clkgen #(
        .HALF_PERIOD  (10),
        .RESET_CYCLES (5)
    ) clkgen0 (
        .clk (clk),
        .rst (rst)
    );

    frontend_top #(
        .START_PC       (START_PC),
        .ROM_DEPTH_LOG2 (ROM_DEPTH_LOG2)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .es_allowin  (es_allowin),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    tb_checker #(
        .START_PC       (START_PC),
        .ROM_DEPTH_LOG2 (ROM_DEPTH_LOG2)
    ) checker0 (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .es_allowin  (es_allowin),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_count (issue_count),
        .error_count (error_count)
    );

    bind decode_stage frontend_chk chk0 (
        .clk         (clk),
        .rst         (rst),
        .es_allowin  (es_allowin),
        .ds_valid    (ds_valid),
        .issue_valid (issue_valid),
        .issue       (issue),
        .redirect    (redirect)
    );

    initial begin : stimulus
        int phase;
        int step;
        void'($urandom(SEED));
        hold       = 1'b0;
        es_allowin = 1'b1;
        phase      = 0;
        step       = 0;
        @(negedge rst);
        @(negedge clk);
        forever begin
            if (phase % 3 == 2) begin // every third phase runs without stalls
                hold       = 1'b0;
                es_allowin = 1'b1;
            end else begin
                hold       = ($urandom % 4) == 0;
                es_allowin = ($urandom % 4) != 0;
            end
            step++;
            if (step == PHASE_LEN) begin
                step = 0;
                phase++;
            end
            @(negedge clk);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    initial begin : finish_run
        int   assert_fails;
        logic timed_out;
        while (issue_count < NUM_ISSUES && cycle_count < MAX_CYCLES) begin
            @(posedge clk);
        end
        timed_out    = issue_count < NUM_ISSUES;
        assert_fails = dut0.decode0.chk0.fail_count;
        if (timed_out) begin
            $display("timeout: only %0d of %0d issues seen within %0d cycles",
                     issue_count, NUM_ISSUES, MAX_CYCLES);
        end
        $display("errors: %0d compare, %0d assertion, %0d timeout (%0d issues checked)",
                 error_count, assert_fails, timed_out ? 1 : 0, issue_count);
        if (error_count == 0 && assert_fails == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: program.hex
// one 32-bit instruction word per line in hex, starting at byte address 0
// the byte address of a line is four times its index
00100093 // 0x00 addi x1, x0, 1
00200113 // 0x04 addi x2, x0, 2
00000463 // 0x08 beq  +8, taken
FFF00F93 // 0x0c wrong path
00001463 // 0x10 bne  +8, not taken
003100B3 // 0x14 add  x1, x2, x3
00004463 // 0x18 blt  +8, not taken
00006463 // 0x1c bltu +8, not taken
00005463 // 0x20 bge  +8, taken
FFF00F93 // 0x24 wrong path
00007863 // 0x28 bgeu +16, taken
FFF00F93 // 0x2c wrong path
FFF00F93 // 0x30 wrong path
FFF00F93 // 0x34 wrong path
00C000EF // 0x38 jal  x1, +12
FFF00F93 // 0x3c wrong path
FFF00F93 // 0x40 wrong path
05100067 // 0x44 jalr x0, 0x51(x0), lands on 0x50
FFF00F93 // 0x48 wrong path
FFF00F93 // 0x4c wrong path
00300193 // 0x50 addi x3, x0, 3
0080006F // 0x54 jal  x0, +8
FFF00F93 // 0x58 wrong path
00000663 // 0x5c beq  +12, taken
FFF00F93 // 0x60 wrong path
FFF00F93 // 0x64 wrong path
00400213 // 0x68 addi x4, x0, 4
F95FF06F // 0x6c jal  x0, -108 back to 0x00

// File: vlog.f
verilog/fe_pkg.sv
verilog/fetch_stage.sv
verilog/inst_rom.sv
verilog/decode_stage.sv
verilog/frontend_top.sv
testbench/tb_clkgen.sv
testbench/frontend_chk.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_top
RTL_TOP    := frontend_top
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
